// ==== logic/memtest_macros.svh ====
`ifndef MEMTEST_MACROS_SVH
`define MEMTEST_MACROS_SVH

// Memory word and CPU word address widths
`define MT_DATA_W 32
`define MT_ADDR_W 30

// Implemented part of the data memory
// Word addresses wrap modulo the depth
`define MT_MEM_AW    8
`define MT_MEM_DEPTH (1 << `MT_MEM_AW)

// Address base stepping between rounds
`define MT_STRIDE    32
`define MT_BASE_INIT 30'h1000

`endif

// ==== logic/memtest_pkg.sv ====
`include "memtest_macros.svh"

package memtest_pkg;

    typedef logic [`MT_DATA_W-1:0] word_t;
    typedef logic [`MT_ADDR_W-1:0] addr_t;
    typedef logic [7:0]            byte_t;

    // Round index, one bit position of the walking one
    typedef logic [2:0] step_t;

    // ------------------------------
    // Stage payloads
    // ------------------------------

    // Sequencer to controller
    typedef struct packed {
        addr_t addr;
        word_t data;
    } round_t;

    // Controller to result stage, strobe marks a completed read
    typedef struct packed {
        word_t rdata;
        word_t expected;
        logic  strobe;
    } result_t;

    // Access controller FSM
    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ
    } ctrl_state_t;

endpackage

// ==== logic/test_sequencer.sv ====
`timescale 1ns/100ps
`include "memtest_macros.svh"

module test_sequencer (
    input  logic                slow_clk,
    input  logic                rst,
    input  logic                run,
    input  logic [15:0]         interval,
    input  logic                busy,
    output logic                start,
    output memtest_pkg::round_t round
);
    import memtest_pkg::*;

    logic [15:0] idle_cnt;
    logic [15:0] interval_q;
    step_t       index;
    addr_t       base;
    byte_t       pattern;
    logic        hold;
    logic        fire;

    // ------------------------------
    // Idle interval
    // ------------------------------

    // No counting while stopped, during a round, or in the start cycle itself
    assign hold = !run || busy || start;
    assign fire = !hold && (idle_cnt == interval_q);

    // Walking one in the low byte
    assign pattern = byte_t'(8'd1 << index);

    always_ff @(posedge slow_clk) begin
        if (!rst) begin
            idle_cnt   <= '0;
            interval_q <= '0;
            start      <= 1'b0;
        end else begin
            start <= fire;
            if (hold || fire) begin
                // Count restarts here, so the interval is taken now
                idle_cnt   <= '0;
                interval_q <= interval;
            end else begin
                idle_cnt <= idle_cnt + 16'd1;
            end
        end
    end

    // ------------------------------
    // Round index and address base
    // ------------------------------

    always_ff @(posedge slow_clk) begin
        if (!rst) begin
            index <= '0;
            base  <= `MT_BASE_INIT;
        end else if (fire) begin
            index <= index + step_t'(1);
            base  <= base + addr_t'(`MT_STRIDE);
        end
    end

    // Round payload, valid while start is high
    always_ff @(posedge slow_clk) begin
        if (fire) begin
            round.addr <= base + addr_t'(index);
            round.data <= word_t'(pattern);
        end
    end

endmodule

// ==== logic/access_controller.sv ====
`timescale 1ns/100ps

module access_controller (
    input  logic                 slow_clk,
    input  logic                 rst,
    input  logic                 start,
    input  memtest_pkg::round_t  round,
    output logic                 busy,
    output logic                 mem_read,
    output logic                 mem_write,
    output memtest_pkg::addr_t   mem_addr,
    output memtest_pkg::word_t   mem_wdata,
    input  logic                 mem_stall,
    input  memtest_pkg::word_t   mem_rdata,
    output memtest_pkg::result_t result
);
    import memtest_pkg::*;

    ctrl_state_t state;
    round_t      round_q;
    logic        strobe_q;
    word_t       rdata_q;
    word_t       expected_q;

    // ------------------------------
    // Write then read FSM
    // ------------------------------

    always_ff @(posedge slow_clk) begin
        if (!rst) begin
            state    <= IDLE;
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    // Level stays up until the memory stops stalling
                    if (!mem_stall) begin
                        state <= READ;
                    end
                end
                READ: begin
                    if (!mem_stall) begin
                        state    <= IDLE;
                        strobe_q <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Round captured at start, held for both accesses
    always_ff @(posedge slow_clk) begin
        if (state == IDLE && start) begin
            round_q <= round;
        end
    end

    // Read word sampled in the completing read cycle
    always_ff @(posedge slow_clk) begin
        if (state == READ && !mem_stall) begin
            rdata_q    <= mem_rdata;
            expected_q <= round_q.data;
        end
    end

    // ------------------------------
    // Memory port levels
    // ------------------------------

    assign busy      = (state != IDLE);
    assign mem_write = (state == WRITE);
    assign mem_read  = (state == READ);
    assign mem_addr  = round_q.addr;
    assign mem_wdata = round_q.data;

    assign result = '{rdata: rdata_q, expected: expected_q, strobe: strobe_q};

endmodule

// ==== logic/stall_memory.sv ====
`timescale 1ns/100ps
`include "memtest_macros.svh"

module stall_memory (
    input  logic               slow_clk,
    input  logic               rst,
    input  logic               mem_read,
    input  logic               mem_write,
    input  memtest_pkg::addr_t mem_addr,
    input  memtest_pkg::word_t mem_wdata,
    input  memtest_pkg::byte_t fault_mask,
    output logic               mem_stall,
    output memtest_pkg::word_t mem_rdata
);
    import memtest_pkg::*;

    word_t                mem [`MT_MEM_DEPTH];
    logic [`MT_MEM_AW-1:0] index;
    logic                 access;
    logic                 pending;
    logic [1:0]           stall_cnt;

    assign index  = mem_addr[`MT_MEM_AW-1:0];
    assign access = mem_read | mem_write;

    // ------------------------------
    // Stall generation
    // ------------------------------

    // First cycle of an access stalls straight from the address bits,
    // later cycles from the loaded counter
    assign mem_stall = pending ? (stall_cnt != 2'd0)
                               : (access && mem_addr[1:0] != 2'd0);

    always_ff @(posedge slow_clk) begin
        if (!rst) begin
            pending   <= 1'b0;
            stall_cnt <= '0;
        end else if (access && !mem_stall) begin
            // Access completes at this edge
            pending <= 1'b0;
        end else if (access && !pending) begin
            pending   <= 1'b1;
            stall_cnt <= mem_addr[1:0] - 2'd1;
        end else if (pending) begin
            stall_cnt <= stall_cnt - 2'd1;
        end
    end

    // ------------------------------
    // Word array
    // ------------------------------

    always_ff @(posedge slow_clk) begin
        if (!rst) begin
            for (int i = 0; i < `MT_MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_write && !mem_stall) begin
            mem[index] <= mem_wdata;
        end
    end

    // Injected faults land on the low byte only
    assign mem_rdata = mem[index] ^ {{(`MT_DATA_W-8){1'b0}}, fault_mask};

endmodule

// ==== logic/result_latch.sv ====
`timescale 1ns/100ps

module result_latch (
    input  logic                 slow_clk,
    input  logic                 rst,
    input  memtest_pkg::result_t result,
    output memtest_pkg::byte_t   led,
    output logic                 round_done,
    output logic [15:0]          error_count
);
    import memtest_pkg::*;

    logic mismatch;
    logic saturated;

    assign mismatch  = (result.rdata != result.expected);
    assign saturated = &error_count;

    // ------------------------------
    // LED byte and round end
    // ------------------------------

    always_ff @(posedge slow_clk) begin
        if (!rst) begin
            led        <= '0;
            round_done <= 1'b0;
        end else begin
            round_done <= result.strobe;
            if (result.strobe) begin
                led <= byte_t'(result.rdata[7:0]);
            end
        end
    end

    // ------------------------------
    // Mismatch counter
    // ------------------------------

    // Full word compared, so faults above the LED byte count too
    always_ff @(posedge slow_clk) begin
        if (!rst) begin
            error_count <= '0;
        end else if (result.strobe && mismatch && !saturated) begin
            error_count <= error_count + 16'd1;
        end
    end

endmodule

// ==== logic/memtest_top.sv ====
`timescale 1ns/100ps

module memtest_top (
    input  logic               slow_clk,
    input  logic               rst,
    input  logic               run,
    input  logic [15:0]        interval,
    input  memtest_pkg::byte_t fault_mask,
    output memtest_pkg::byte_t led,
    output logic               round_done,
    output logic [15:0]        error_count,
    output logic               busy
);
    import memtest_pkg::*;

    logic    start;
    round_t  round;
    logic    mem_read;
    logic    mem_write;
    addr_t   mem_addr;
    word_t   mem_wdata;
    logic    mem_stall;
    word_t   mem_rdata;
    result_t result;

    test_sequencer u_test_sequencer (
        .slow_clk (slow_clk),
        .rst      (rst),
        .run      (run),
        .interval (interval),
        .busy     (busy),
        .start    (start),
        .round    (round)
    );

    access_controller u_access_controller (
        .slow_clk  (slow_clk),
        .rst       (rst),
        .start     (start),
        .round     (round),
        .busy      (busy),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_stall (mem_stall),
        .mem_rdata (mem_rdata),
        .result    (result)
    );

    stall_memory u_stall_memory (
        .slow_clk   (slow_clk),
        .rst        (rst),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .fault_mask (fault_mask),
        .mem_stall  (mem_stall),
        .mem_rdata  (mem_rdata)
    );

    result_latch u_result_latch (
        .slow_clk    (slow_clk),
        .rst         (rst),
        .result      (result),
        .led         (led),
        .round_done  (round_done),
        .error_count (error_count)
    );

endmodule

// ==== bench/memtest_properties.sv ====
`timescale 1ns/100ps

module memtest_properties (
    input logic                     slow_clk,
    input logic                     rst,
    input memtest_pkg::ctrl_state_t state,
    input logic                     busy,
    input logic                     mem_read,
    input logic                     mem_write,
    input logic                     mem_stall
);
    import memtest_pkg::*;

    // Failure tallies, read by the testbench at the end of the run
    int unsigned overlap_failures = 0;
    int unsigned write_failures   = 0;
    int unsigned read_failures    = 0;
    int unsigned idle_failures    = 0;

    // ------------------------------
    // Memory port levels
    // ------------------------------

    a_one_level: assert property (@(posedge slow_clk) disable iff (!rst)
        !(mem_read && mem_write))
    else begin
        $error("mem_read and mem_write are high together");
        overlap_failures++;
    end

    // A stalled access keeps its level for the next cycle
    a_write_held: assert property (@(posedge slow_clk) disable iff (!rst)
        mem_write && mem_stall |=> mem_write)
    else begin
        $error("mem_write dropped while the memory was stalling");
        write_failures++;
    end

    a_read_held: assert property (@(posedge slow_clk) disable iff (!rst)
        mem_read && mem_stall |=> mem_read)
    else begin
        $error("mem_read dropped while the memory was stalling");
        read_failures++;
    end

    // ------------------------------
    // Controller FSM
    // ------------------------------

    a_idle_not_busy: assert property (@(posedge slow_clk) disable iff (!rst)
        state == IDLE |-> !busy)
    else begin
        $error("busy is high in the IDLE state");
        idle_failures++;
    end

endmodule

bind access_controller memtest_properties u_memtest_properties (
    .slow_clk  (slow_clk),
    .rst       (rst),
    .state     (state),
    .busy      (busy),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_stall (mem_stall)
);

// ==== bench/memtest_tb.sv ====
`timescale 1ns/100ps
`include "memtest_macros.svh"

module memtest_tb;
    import memtest_pkg::*;

    localparam int TOTAL_ROUNDS = 16 + 16 + 12 + 30 + 1;
    localparam int IDLE_CYCLES  = 4 + 1 + 40 + 40;
    // Longest interval plus longest write and read per round
    localparam int CYCLE_LIMIT  = TOTAL_ROUNDS * (15 + 10) + IDLE_CYCLES + 300;

    logic        slow_clk;
    logic        rst;
    logic        run;
    logic [15:0] interval;
    byte_t       fault_mask;
    byte_t       led;
    logic        round_done;
    logic [15:0] error_count;
    logic        busy;

    // Reference model
    step_t       model_index;
    byte_t       model_pattern;
    addr_t       model_base;
    int unsigned model_rounds;
    int unsigned model_errors;

    logic        busy_prev;
    int unsigned busy_rises;
    logic [31:0] lcg_state;
    int unsigned checks;
    int unsigned errors;
    int unsigned test_errors_at_start;
    int unsigned assertion_failures;
    int unsigned cycle_cnt = 0;

    memtest_top u_memtest_top (
        .slow_clk    (slow_clk),
        .rst         (rst),
        .run         (run),
        .interval    (interval),
        .fault_mask  (fault_mask),
        .led         (led),
        .round_done  (round_done),
        .error_count (error_count),
        .busy        (busy)
    );

    initial slow_clk = 1'b0;
    always #10 slow_clk = ~slow_clk;

    always @(posedge slow_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("TIMEOUT after %0d cycles, round_done stopped arriving", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Sample and drive point 2 ns after the rising edge
    task automatic tick();
        @(posedge slow_clk);
        #2;
        if (busy && !busy_prev) begin
            busy_rises++;
        end
        busy_prev = busy;
    endtask

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (actual == expected) else begin
            $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("ERROR time=%0t %s", $time, what);
            errors++;
        end
    endtask

    // New mask and interval for the round after this one
    task automatic draw_stimulus(input bit masked, input bit zero_iv);
        lcg_state = lcg_next(lcg_state);
        interval  = zero_iv ? 16'd0 : {12'd0, lcg_state[19:16]};
        if (masked) begin
            fault_mask = (lcg_state[31:24] == 8'd0) ? 8'h80 : lcg_state[31:24];
        end else begin
            fault_mask = 8'd0;
        end
    endtask

    // Compare one finished round with the model, then advance the model
    task automatic score_round();
        byte_t                 onehot;
        addr_t                 addr;
        logic [`MT_MEM_AW-1:0] mem_idx;
        onehot  = model_pattern;
        addr    = model_base + addr_t'(model_index);
        mem_idx = addr[`MT_MEM_AW-1:0];
        if (fault_mask != 8'd0) begin
            model_errors++;
        end
        expect_equal("led", 32'(onehot ^ fault_mask), 32'(led));
        expect_equal("error_count", model_errors, 32'(error_count));
        expect_equal("mem word", word_t'(onehot), u_memtest_top.u_stall_memory.mem[mem_idx]);
        expect_equal("busy rises", model_rounds + 1, busy_rises);
        expect_true(!busy, "busy still high in the round_done cycle");
        model_index   = model_index + step_t'(1);
        // Walking one moves up a bit and wraps from bit 7 to bit 0
        model_pattern = {model_pattern[6:0], model_pattern[7]};
        model_base    = model_base + addr_t'(`MT_STRIDE);
        model_rounds++;
    endtask

    task automatic run_rounds(input int n, input bit masked, input bit zero_iv,
                              input bit next_masked);
        for (int i = 0; i < n; i++) begin
            do begin
                tick();
            end while (!round_done);
            score_round();
            draw_stimulus((i == n - 1) ? next_masked : masked, zero_iv);
        end
    endtask

    task automatic report_test(input int num, input string name);
        int unsigned n;
        string       verdict;
        n = errors - test_errors_at_start;
        if (n == 0) begin
            verdict = "ok";
        end else begin
            verdict = "FAIL";
        end
        $display("test %0d %s %s (%0d errors)", num, name, verdict, n);
        test_errors_at_start = errors;
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        rst           = 1'b0;
        run           = 1'b0;
        interval      = 16'd0;
        fault_mask    = 8'd0;
        lcg_state     = 32'hb244;
        model_index   = '0;
        model_pattern = 8'h01;
        model_base    = `MT_BASE_INIT;
        model_rounds  = 0;
        model_errors  = 0;
        busy_prev     = 1'b0;
        busy_rises    = 0;
        checks        = 0;
        errors        = 0;
        test_errors_at_start = 0;

        repeat (4) @(posedge slow_clk);
        #2 rst = 1'b1;

        // Reset values and no activity while run is low
        expect_equal("led", 32'd0, 32'(led));
        expect_equal("error_count", 32'd0, 32'(error_count));
        expect_equal("busy", 32'd0, 32'(busy));
        expect_equal("round_done", 32'd0, 32'(round_done));
        repeat (40) begin
            tick();
            expect_true(!round_done && !busy, "activity while run is low");
        end
        report_test(1, "reset idle");

        // Clean walking one
        draw_stimulus(1'b0, 1'b0);
        run = 1'b1;
        run_rounds(16, 1'b0, 1'b0, 1'b1);
        report_test(2, "walking one");

        // Injected faults
        run_rounds(16, 1'b1, 1'b0, 1'b0);
        report_test(3, "fault mask");

        // Base keeps stepping and the memory index wraps
        run_rounds(12, 1'b0, 1'b0, 1'b0);
        report_test(4, "stride wrap");

        // Back to back rounds
        interval = 16'd0;
        run_rounds(30, 1'b0, 1'b1, 1'b0);
        report_test(5, "back pressure");

        // Run drops while a round is in flight
        do begin
            tick();
        end while (!busy);
        run = 1'b0;
        do begin
            tick();
        end while (!round_done);
        score_round();
        repeat (40) begin
            tick();
            expect_true(!round_done && !busy, "round started after run went low");
        end
        report_test(6, "run drop");

        assertion_failures =
            u_memtest_top.u_access_controller.u_memtest_properties.overlap_failures +
            u_memtest_top.u_access_controller.u_memtest_properties.write_failures +
            u_memtest_top.u_access_controller.u_memtest_properties.read_failures +
            u_memtest_top.u_access_controller.u_memtest_properties.idle_failures;

        $display("summary: tests=6 rounds=%0d checks=%0d errors=%0d assertion_failures=%0d",
                 model_rounds, checks, errors, assertion_failures);
        if (errors == 0 && assertion_failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+logic
logic/memtest_pkg.sv
logic/test_sequencer.sv
logic/access_controller.sv
logic/stall_memory.sv
logic/result_latch.sv
logic/memtest_top.sv
bench/memtest_properties.sv
bench/memtest_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory self-test simulation with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module memtest_tb \
        -f project.f -o memtest_sim; then
    echo "verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench can report them
output=$(./obj_dir/memtest_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
